// File: project.f
verilog/csr_pkg.sv
verilog/perf_pkg.sv
verilog/csr_access_arbiter.sv
verilog/csr_regfile.sv
verilog/perf_counters.sv
verilog/csr_subsys_top.sv
verification/tb_clock_gen.sv
verification/csr_subsys_chk.sv
verification/csr_tb.sv

// File: run.sh
#!/bin/sh
# build and run the csr subsystem simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module csr_tb -o sim_csr
./obj_dir/sim_csr > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi

// File: verification/csr_subsys_chk.sv
// credit and response protocol assertions for the csr subsystem, bound to the top
`timescale 1ns/1ns
`default_nettype none

module csr_subsys_chk import csr_pkg::*;
(
  input wire logic clk,
  input wire logic rst_n,
  input wire logic core_req_valid_i,
  input wire logic core_credit_o,
  input wire logic core_rsp_valid_o,
  input wire logic dbg_req_valid_i,
  input wire logic dbg_credit_o,
  input wire logic dbg_rsp_valid_o
);

  int core_cred;
  int dbg_cred;

  // credits held by each requester
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      core_cred <= REQ_CREDITS;
      dbg_cred  <= REQ_CREDITS;
    end
    else
    begin
      core_cred <= core_cred + int'(core_credit_o) - int'(core_req_valid_i);
      dbg_cred  <= dbg_cred + int'(dbg_credit_o) - int'(dbg_req_valid_i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////////////////////////

  core_cred_max: assert property (@(posedge clk) disable iff (!rst_n)
    core_cred <= REQ_CREDITS) else $error("core credits above queue depth");
  dbg_cred_max: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_cred <= REQ_CREDITS) else $error("debug credits above queue depth");

  // no request without a credit in hand
  core_spend: assert property (@(posedge clk) disable iff (!rst_n)
    core_req_valid_i |-> core_cred > 0) else $error("core request without credit");
  dbg_spend: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_req_valid_i |-> dbg_cred > 0) else $error("debug request without credit");

  // response one cycle after the pop that returned the credit
  core_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_valid_o |-> $past(core_credit_o)) else $error("core response without pop");
  dbg_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_rsp_valid_o |-> $past(dbg_credit_o)) else $error("debug response without pop");

endmodule

bind csr_subsys_top csr_subsys_chk u_chk (
  .clk              (clk),
  .rst_n            (rst_n),
  .core_req_valid_i (core_req_valid_i),
  .core_credit_o    (core_credit_o),
  .core_rsp_valid_o (core_rsp_valid_o),
  .dbg_req_valid_i  (dbg_req_valid_i),
  .dbg_credit_o     (dbg_credit_o),
  .dbg_rsp_valid_o  (dbg_rsp_valid_o)
);

`default_nettype wire

// File: verification/csr_tb.sv
// testbench top with requester models, directed tests, check task and watchdog
`timescale 1ns/1ns
`default_nettype none

module csr_tb import csr_pkg::*, perf_pkg::*;
();

  localparam int N_TESTS = 5;
  localparam hart_id_t HART = 10'h2A5;

  logic clk;
  logic rst_n;
  logic req_valid [2];
  csr_addr_t req_addr [2];
  csr_op_t req_op [2];
  csr_data_t req_wdata [2];
  logic credit [2];
  logic rsp_valid [2];
  csr_data_t rsp_rdata [2];
  csr_data_t pc;
  logic save_pc;
  cause_t cause;
  logic save_cause;
  event_vec_t events;
  logic irq_enable;
  csr_data_t epc;

  int credits [2];
  csr_data_t exp_core [$];
  logic care_core [$];
  csr_data_t exp_dbg [$];
  logic care_dbg [$];
  csr_data_t last_rsp;
  logic [31:0] seed;
  string cur_test;
  csr_data_t sh_scratch;
  csr_data_t sh_epc;

  tb_clock_gen u_clk (.clk_o(clk));

  csr_subsys_top uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .core_req_valid_i (req_valid[0]),
    .core_req_addr_i  (req_addr[0]),
    .core_req_op_i    (req_op[0]),
    .core_req_wdata_i (req_wdata[0]),
    .core_credit_o    (credit[0]),
    .core_rsp_valid_o (rsp_valid[0]),
    .core_rsp_rdata_o (rsp_rdata[0]),
    .dbg_req_valid_i  (req_valid[1]),
    .dbg_req_addr_i   (req_addr[1]),
    .dbg_req_op_i     (req_op[1]),
    .dbg_req_wdata_i  (req_wdata[1]),
    .dbg_credit_o     (credit[1]),
    .dbg_rsp_valid_o  (rsp_valid[1]),
    .dbg_rsp_rdata_o  (rsp_rdata[1]),
    .hart_id_i        (HART),
    .pc_i             (pc),
    .save_pc_i        (save_pc),
    .cause_i          (cause),
    .save_cause_i     (save_cause),
    .events_i         (events),
    .irq_enable_o     (irq_enable),
    .epc_o            (epc)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // expected register value after an op
  function automatic csr_data_t model_op(csr_op_t op, csr_data_t old_v, csr_data_t wd);
    if (op == CSR_OP_WRITE)
      return wd;
    else if (op == CSR_OP_SET)
      return old_v | wd;
    else if (op == CSR_OP_CLEAR)
      return old_v & ~wd;
    return old_v;
  endfunction

  task automatic check(string name, csr_data_t exp_v, csr_data_t act_v);
    if (exp_v !== act_v)
    begin
      $display("** Error %s: expected %h actual %h", name, exp_v, act_v);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // requester credit count, a valid cycle spends one
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credits[0] <= REQ_CREDITS;
      credits[1] <= REQ_CREDITS;
    end
    else
    begin
      credits[0] <= credits[0] + int'(credit[0]) - int'(req_valid[0]);
      credits[1] <= credits[1] + int'(credit[1]) - int'(req_valid[1]);
    end
  end

  // in-order response compare per port
  always @(posedge clk)
  begin
    if (rst_n && rsp_valid[0])
    begin
      if (exp_core.size() == 0)
      begin
        $display("core port returned a response that was never requested");
        $display("RESULT: FAIL");
        $fatal(1);
      end
      last_rsp = rsp_rdata[0];
      if (care_core.pop_front())
        check({cur_test, " core"}, exp_core[0], rsp_rdata[0]);
      void'(exp_core.pop_front());
    end
    if (rst_n && rsp_valid[1])
    begin
      if (exp_dbg.size() == 0)
      begin
        $display("debug port returned a response that was never requested");
        $display("RESULT: FAIL");
        $fatal(1);
      end
      if (care_dbg.pop_front())
        check({cur_test, " dbg"}, exp_dbg[0], rsp_rdata[1]);
      void'(exp_dbg.pop_front());
    end
  end

  // caller sits just after a rising edge; waits for a credit, then one valid cycle
  task automatic send(int p, csr_addr_t a, csr_op_t op, csr_data_t wd,
                      csr_data_t exp_v, logic care);
    while (credits[p] - int'(req_valid[p]) <= 0)
    begin
      req_valid[p] <= 1'b0;
      @(posedge clk);
    end
    req_valid[p] <= 1'b1;
    req_addr[p]  <= a;
    req_op[p]    <= op;
    req_wdata[p] <= wd;
    if (p == 0)
    begin
      exp_core.push_back(exp_v);
      care_core.push_back(care);
    end
    else
    begin
      exp_dbg.push_back(exp_v);
      care_dbg.push_back(care);
    end
    @(posedge clk);
    req_valid[p] <= 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_core.size() != 0 || exp_dbg.size() != 0)
      @(posedge clk);
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_rmw();
    csr_data_t a;
    csr_data_t b;
    csr_data_t c;
    cur_test = "rmw";
    a = lcg_next();
    b = lcg_next();
    c = lcg_next();
    // mscratch has no reset value
    send(0, CSR_MSCRATCH, CSR_OP_WRITE, a, '0, 1'b0);
    send(0, CSR_MSCRATCH, CSR_OP_SET, b, a, 1'b1);
    send(0, CSR_MSCRATCH, CSR_OP_CLEAR, c, a | b, 1'b1);
    send(0, CSR_MSCRATCH, CSR_OP_NONE, '0, (a | b) & ~c, 1'b1);
    sh_scratch = (a | b) & ~c;
    send(0, CSR_MHARTID, CSR_OP_WRITE, lcg_next(), {22'b0, HART}, 1'b1);
    send(0, CSR_MHARTID, CSR_OP_NONE, '0, {22'b0, HART}, 1'b1);
    send(0, 12'h123, CSR_OP_WRITE, lcg_next(), '0, 1'b1);
    send(0, 12'h123, CSR_OP_NONE, '0, '0, 1'b1);
    wait_idle();
  endtask

  task automatic test_trap();
    cur_test = "trap";
    send(0, CSR_MSTATUS, CSR_OP_WRITE, 32'h1, 32'h6, 1'b1);
    wait_idle();
    check("trap irq_enable", 32'h1, {31'b0, irq_enable});
    send(0, CSR_MSTATUS, CSR_OP_NONE, '0, 32'h7, 1'b1);
    pc <= lcg_next();
    cause <= 6'b100111;
    // pulse lands in the pop cycle of this mepc write
    send(0, CSR_MEPC, CSR_OP_WRITE, lcg_next(), '0, 1'b0);
    save_pc    <= 1'b1;
    save_cause <= 1'b1;
    @(posedge clk);
    save_pc    <= 1'b0;
    save_cause <= 1'b0;
    wait_idle();
    check("trap epc_o", pc, epc);
    sh_epc = pc;
    send(0, CSR_MEPC, CSR_OP_NONE, '0, pc, 1'b1);
    send(0, CSR_MCAUSE, CSR_OP_NONE, '0, 32'h8000_0007, 1'b1);
    wait_idle();
  endtask

  task automatic burst(int p);
    csr_op_t op;
    csr_data_t wd;
    for (int i = 0; i < 6; i++)
    begin
      op = csr_op_t'(lcg_next() % 4);
      wd = lcg_next();
      if (p == 0)
      begin
        send(0, CSR_MSCRATCH, op, wd, sh_scratch, 1'b1);
        sh_scratch = model_op(op, sh_scratch, wd);
      end
      else
      begin
        send(1, CSR_MEPC, op, wd, sh_epc, 1'b1);
        sh_epc = model_op(op, sh_epc, wd);
      end
    end
  endtask

  task automatic test_arb();
    cur_test = "arb";
    fork
      burst(0);
      burst(1);
    join
    wait_idle();
    check("arb core credits", REQ_CREDITS, credits[0]);
    check("arb dbg credits", REQ_CREDITS, credits[1]);
    send(0, CSR_MEPC, CSR_OP_NONE, '0, sh_epc, 1'b1);
    send(1, CSR_MSCRATCH, CSR_OP_NONE, '0, sh_scratch, 1'b1);
    wait_idle();
  endtask

  task automatic test_events();
    cur_test = "events";
    send(0, CSR_PCER, CSR_OP_WRITE, 32'h0C, '0, 1'b1);
    send(0, CSR_PCCR_ALL, CSR_OP_WRITE, '0, '0, 1'b1);
    wait_idle();
    // 5 loads, 3 stores, instr is not enabled
    for (int i = 0; i < 8; i++)
    begin
      events <= '0;
      events[EV_LOAD]  <= (i < 5);
      events[EV_STORE] <= (i < 3);
      events[EV_INSTR] <= 1'b1;
      @(posedge clk);
    end
    events <= '0;
    repeat (3) @(posedge clk);
    send(0, CSR_PCCR_BASE + 12'd2, CSR_OP_NONE, '0, 32'd5, 1'b1);
    send(0, CSR_PCCR_BASE + 12'd3, CSR_OP_NONE, '0, 32'd3, 1'b1);
    send(0, CSR_PCCR_BASE + 12'd1, CSR_OP_NONE, '0, 32'd0, 1'b1);
    send(0, CSR_PCMR, CSR_OP_CLEAR, 32'h1, 32'h3, 1'b1);
    wait_idle();
    // frozen
    events[EV_LOAD] <= 1'b1;
    repeat (4) @(posedge clk);
    events <= '0;
    repeat (3) @(posedge clk);
    send(0, CSR_PCCR_BASE + 12'd2, CSR_OP_NONE, '0, 32'd5, 1'b1);
    wait_idle();
  endtask

  task automatic test_sat();
    cur_test = "sat";
    send(0, CSR_PCER, CSR_OP_WRITE, 32'h1, 32'h0C, 1'b1);
    send(0, CSR_PCMR, CSR_OP_WRITE, 32'h3, 32'h2, 1'b1);
    send(0, CSR_PCCR_BASE, CSR_OP_WRITE, 32'hFFFF_FFF0, 32'h0, 1'b1);
    wait_idle();
    repeat (30) @(posedge clk);
    send(0, CSR_PCCR_BASE, CSR_OP_NONE, '0, 32'hFFFF_FFFF, 1'b1);
    // reload while still held at all ones
    send(0, CSR_PCCR_BASE, CSR_OP_WRITE, 32'hFFFF_FFF0, 32'hFFFF_FFFF, 1'b1);
    send(0, CSR_PCMR, CSR_OP_CLEAR, 32'h2, 32'h3, 1'b1);
    wait_idle();
    repeat (30) @(posedge clk);
    send(0, CSR_PCCR_BASE, CSR_OP_NONE, '0, '0, 1'b0);
    wait_idle();
    // wrapped past zero
    check("sat wrap", 32'h1, {31'b0, last_rsp < 32'd100});
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    seed       = 32'hecb4bbba;
    rst_n      = 1'b0;
    pc         = '0;
    save_pc    = 1'b0;
    cause      = '0;
    save_cause = 1'b0;
    events     = '0;
    for (int p = 0; p < 2; p++)
    begin
      req_valid[p] = 1'b0;
      req_addr[p]  = '0;
      req_op[p]    = CSR_OP_NONE;
      req_wdata[p] = '0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_rmw();
    test_trap();
    test_arb();
    test_events();
    test_sat();
    $display("RESULT: PASS");
    $finish;
  end

  // 200 cycles of 4 ns per test
  initial
  begin
    #(N_TESTS * 200 * 4);
    $display("watchdog expired before the tests completed");
    $display("RESULT: FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// testbench clock source, 4 ns period
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
  output logic clk_o
);

  // 2 ns half period
  initial
  begin
    clk_o = 1'b0;
  end

  always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: verilog/csr_access_arbiter.sv
// two-port csr access arbiter with credit queues, round robin and response return
`timescale 1ns/1ns
`default_nettype none

module csr_access_arbiter import csr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,

  // requester side
  input  logic [N_PORTS-1:0]   req_valid_i,
  input  csr_addr_t            req_addr_i  [N_PORTS],
  input  csr_op_t              req_op_i    [N_PORTS],
  input  csr_data_t            req_wdata_i [N_PORTS],
  output logic [N_PORTS-1:0]   credit_o,
  output logic [N_PORTS-1:0]   rsp_valid_o,
  output csr_data_t            rsp_rdata_o [N_PORTS],

  // shared access bus
  output logic                 acc_valid_o,
  output csr_addr_t            acc_addr_o,
  output csr_op_t              acc_op_o,
  output csr_data_t            acc_wdata_o,
  input  logic                 csr_hit_i,
  input  csr_data_t            csr_rdata_i,
  input  logic                 perf_hit_i,
  input  csr_data_t            perf_rdata_i
);

  typedef logic [PORT_W-1:0] port_idx_t;
  typedef logic [QPTR_W-1:0] qptr_t;
  typedef logic [QCNT_W-1:0] qcnt_t;

  // serve means a response goes out this cycle
  typedef enum logic {IDLE, SERVE} arb_state_e;

  // queue storage
  csr_addr_t  q_addr  [N_PORTS][REQ_CREDITS];
  csr_op_t    q_op    [N_PORTS][REQ_CREDITS];
  csr_data_t  q_wdata [N_PORTS][REQ_CREDITS];

  qptr_t      wr_ptr_q [N_PORTS];
  qptr_t      rd_ptr_q [N_PORTS];
  qcnt_t      cnt_q    [N_PORTS];

  logic [N_PORTS-1:0] push;
  logic [N_PORTS-1:0] pop;
  logic               pop_valid;
  port_idx_t          pop_port;
  port_idx_t          rr_q;
  port_idx_t          served_q;
  arb_state_e         state_q;
  csr_data_t          rsp_data_q;

  //////////////////////////////////////////////////////////////////////
  // round robin pick
  //////////////////////////////////////////////////////////////////////

  // start one past the last served port
  always_comb
  begin
    int cand;
    pop_valid = 1'b0;
    pop_port  = rr_q;
    for (int k = 1; k <= N_PORTS; k++)
    begin
      cand = (int'(rr_q) + k) % N_PORTS;
      if (!pop_valid && (cnt_q[cand] != '0))
      begin
        pop_valid = 1'b1;
        pop_port  = port_idx_t'(cand);
      end
    end
  end

  // push only with room, a request without credit is dropped here
  always_comb
  begin
    for (int p = 0; p < N_PORTS; p++)
    begin
      push[p] = req_valid_i[p] && (cnt_q[p] != qcnt_t'(REQ_CREDITS));
      pop[p]  = pop_valid && (int'(pop_port) == p);
    end
  end

  // credit goes back in the pop cycle
  assign credit_o = pop;

  // head of the chosen queue onto the bus
  assign acc_valid_o = pop_valid;
  assign acc_addr_o  = q_addr[pop_port][rd_ptr_q[pop_port]];
  assign acc_op_o    = q_op[pop_port][rd_ptr_q[pop_port]];
  assign acc_wdata_o = q_wdata[pop_port][rd_ptr_q[pop_port]];

  //////////////////////////////////////////////////////////////////////
  // queue control and grant state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int p = 0; p < N_PORTS; p++)
      begin
        wr_ptr_q[p] <= '0;
        rd_ptr_q[p] <= '0;
        cnt_q[p]    <= '0;
      end
      // port 0 goes first
      rr_q     <= port_idx_t'(N_PORTS - 1);
      served_q <= '0;
      state_q  <= IDLE;
    end
    else
    begin
      for (int p = 0; p < N_PORTS; p++)
      begin
        if (push[p])
          wr_ptr_q[p] <= (wr_ptr_q[p] == qptr_t'(REQ_CREDITS - 1)) ? '0 : wr_ptr_q[p] + 1'b1;
        if (pop[p])
          rd_ptr_q[p] <= (rd_ptr_q[p] == qptr_t'(REQ_CREDITS - 1)) ? '0 : rd_ptr_q[p] + 1'b1;
        cnt_q[p] <= cnt_q[p] + qcnt_t'(push[p]) - qcnt_t'(pop[p]);
      end
      if (pop_valid)
      begin
        rr_q     <= pop_port;
        served_q <= pop_port;
      end
      state_q <= pop_valid ? SERVE : IDLE;
    end
  end

  // entry write and response capture
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < N_PORTS; p++)
    begin
      if (push[p])
      begin
        q_addr[p][wr_ptr_q[p]]  <= req_addr_i[p];
        q_op[p][wr_ptr_q[p]]    <= req_op_i[p];
        q_wdata[p][wr_ptr_q[p]] <= req_wdata_i[p];
      end
    end
    // counter block wins, a miss on both reads zero
    if (pop_valid)
      rsp_data_q <= perf_hit_i ? perf_rdata_i : (csr_hit_i ? csr_rdata_i : '0);
  end

  // steer the response to the port served last cycle
  always_comb
  begin
    for (int p = 0; p < N_PORTS; p++)
    begin
      rsp_valid_o[p] = (state_q == SERVE) && (int'(served_q) == p);
      rsp_rdata_o[p] = rsp_valid_o[p] ? rsp_data_q : '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/csr_pkg.sv
// csr address map, access op encoding, data types, arbiter sizing, op helper
`default_nettype none

package csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // basic types
  //////////////////////////////////////////////////////////////////////

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  // top bit flags an interrupt, low 5 bits hold the code
  typedef logic [5:0]  cause_t;
  typedef logic [9:0]  hart_id_t;

  // access op, none is a plain read
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_t;

  //////////////////////////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MHARTID   = 12'hF10;
  // performance block
  localparam csr_addr_t CSR_PCER      = 12'h7A0;
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;
  localparam csr_addr_t CSR_PCCR_ALL  = 12'h79F;

  // requester count and per-port queue depth
  localparam int N_PORTS     = 2;
  localparam int REQ_CREDITS = 2;
  localparam int PORT_W      = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;
  localparam int QPTR_W      = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
  localparam int QCNT_W      = $clog2(REQ_CREDITS + 1);

  // new register value for an op, clear is old and not wdata
  function automatic csr_data_t csr_apply_op(csr_op_t op, csr_data_t old_val,
                                             csr_data_t wdata);
    case (op)
      CSR_OP_WRITE: return wdata;
      CSR_OP_SET:   return old_val | wdata;
      CSR_OP_CLEAR: return old_val & ~wdata;
      default:      return old_val;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: verilog/csr_regfile.sv
// machine csrs with read-modify-write access and trap capture
`timescale 1ns/1ns
`default_nettype none

module csr_regfile import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // access bus
  input  logic      acc_valid_i,
  input  csr_addr_t acc_addr_i,
  input  csr_op_t   acc_op_i,
  input  csr_data_t acc_wdata_i,

  input  hart_id_t  hart_id_i,

  // trap capture
  input  csr_data_t pc_i,
  input  logic      save_pc_i,
  input  cause_t    cause_i,
  input  logic      save_cause_i,

  output logic      hit_o,
  output csr_data_t rdata_o,
  output logic      irq_enable_o,
  output csr_data_t epc_o
);

  logic      ie_q;
  csr_data_t mscratch_q;
  csr_data_t mepc_q;
  cause_t    mcause_q;

  logic      sel_mstatus;
  logic      sel_mscratch;
  logic      sel_mepc;
  logic      sel_mcause;
  logic      sel_mhartid;
  logic      wr_en;
  csr_data_t new_val;

  //////////////////////////////////////////////////////////////////////
  // decode and read
  //////////////////////////////////////////////////////////////////////

  assign sel_mstatus  = acc_valid_i && (acc_addr_i == CSR_MSTATUS);
  assign sel_mscratch = acc_valid_i && (acc_addr_i == CSR_MSCRATCH);
  assign sel_mepc     = acc_valid_i && (acc_addr_i == CSR_MEPC);
  assign sel_mcause   = acc_valid_i && (acc_addr_i == CSR_MCAUSE);
  assign sel_mhartid  = acc_valid_i && (acc_addr_i == CSR_MHARTID);

  assign hit_o = sel_mstatus | sel_mscratch | sel_mepc | sel_mcause | sel_mhartid;

  // old value, returned as the response
  always_comb
  begin
    rdata_o = '0;
    // always M mode, only IE is live
    if (sel_mstatus)
      rdata_o = {29'b0, 2'b11, ie_q};
    if (sel_mscratch)
      rdata_o = mscratch_q;
    if (sel_mepc)
      rdata_o = mepc_q;
    // flag up in bit 31, code at the bottom
    if (sel_mcause)
      rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
    if (sel_mhartid)
      rdata_o = {22'b0, hart_id_i};
  end

  // op applied to the old value
  assign wr_en   = acc_valid_i && (acc_op_i != CSR_OP_NONE);
  assign new_val = csr_apply_op(acc_op_i, rdata_o, acc_wdata_i);

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ie_q     <= 1'b0;
      mcause_q <= '0;
    end
    else
    begin
      if (wr_en && sel_mstatus)
        ie_q <= new_val[0];
      // trap beats the bus
      if (save_cause_i)
        mcause_q <= cause_i;
      else if (wr_en && sel_mcause)
        mcause_q <= {new_val[31], new_val[4:0]};
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en && sel_mscratch)
      mscratch_q <= new_val;
    // saved pc overrides a same-cycle write
    if (save_pc_i)
      mepc_q <= pc_i;
    else if (wr_en && sel_mepc)
      mepc_q <= new_val;
  end

  // mhartid writes fall through, nothing stored

  assign irq_enable_o = ie_q;
  assign epc_o        = mepc_q;

endmodule

`default_nettype wire

// File: verilog/csr_subsys_top.sv
// csr subsystem top with arbiter, machine register file and perf counters
`timescale 1ns/1ns
`default_nettype none

module csr_subsys_top import csr_pkg::*, perf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // core requester
  input  logic       core_req_valid_i,
  input  csr_addr_t  core_req_addr_i,
  input  csr_op_t    core_req_op_i,
  input  csr_data_t  core_req_wdata_i,
  output logic       core_credit_o,
  output logic       core_rsp_valid_o,
  output csr_data_t  core_rsp_rdata_o,

  // debug requester
  input  logic       dbg_req_valid_i,
  input  csr_addr_t  dbg_req_addr_i,
  input  csr_op_t    dbg_req_op_i,
  input  csr_data_t  dbg_req_wdata_i,
  output logic       dbg_credit_o,
  output logic       dbg_rsp_valid_o,
  output csr_data_t  dbg_rsp_rdata_o,

  input  hart_id_t   hart_id_i,
  input  csr_data_t  pc_i,
  input  logic       save_pc_i,
  input  cause_t     cause_i,
  input  logic       save_cause_i,
  input  event_vec_t events_i,

  output logic       irq_enable_o,
  output csr_data_t  epc_o
);

  //////////////////////////////////////////////////////////////////////
  // port packing, core is port 0
  //////////////////////////////////////////////////////////////////////

  logic [N_PORTS-1:0] req_valid;
  csr_addr_t          req_addr  [N_PORTS];
  csr_op_t            req_op    [N_PORTS];
  csr_data_t          req_wdata [N_PORTS];
  logic [N_PORTS-1:0] credit;
  logic [N_PORTS-1:0] rsp_valid;
  csr_data_t          rsp_rdata [N_PORTS];

  // shared access bus
  logic      acc_valid;
  csr_addr_t acc_addr;
  csr_op_t   acc_op;
  csr_data_t acc_wdata;
  logic      csr_hit;
  csr_data_t csr_rdata;
  logic      perf_hit;
  csr_data_t perf_rdata;

  assign req_valid    = {dbg_req_valid_i, core_req_valid_i};
  assign req_addr[0]  = core_req_addr_i;
  assign req_addr[1]  = dbg_req_addr_i;
  assign req_op[0]    = core_req_op_i;
  assign req_op[1]    = dbg_req_op_i;
  assign req_wdata[0] = core_req_wdata_i;
  assign req_wdata[1] = dbg_req_wdata_i;

  assign core_credit_o    = credit[0];
  assign dbg_credit_o     = credit[1];
  assign core_rsp_valid_o = rsp_valid[0];
  assign dbg_rsp_valid_o  = rsp_valid[1];
  assign core_rsp_rdata_o = rsp_rdata[0];
  assign dbg_rsp_rdata_o  = rsp_rdata[1];

  //////////////////////////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////////////////////////

  csr_access_arbiter u_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_addr_i   (req_addr),
    .req_op_i     (req_op),
    .req_wdata_i  (req_wdata),
    .credit_o     (credit),
    .rsp_valid_o  (rsp_valid),
    .rsp_rdata_o  (rsp_rdata),
    .acc_valid_o  (acc_valid),
    .acc_addr_o   (acc_addr),
    .acc_op_o     (acc_op),
    .acc_wdata_o  (acc_wdata),
    .csr_hit_i    (csr_hit),
    .csr_rdata_i  (csr_rdata),
    .perf_hit_i   (perf_hit),
    .perf_rdata_i (perf_rdata)
  );

  csr_regfile u_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .acc_valid_i  (acc_valid),
    .acc_addr_i   (acc_addr),
    .acc_op_i     (acc_op),
    .acc_wdata_i  (acc_wdata),
    .hart_id_i    (hart_id_i),
    .pc_i         (pc_i),
    .save_pc_i    (save_pc_i),
    .cause_i      (cause_i),
    .save_cause_i (save_cause_i),
    .hit_o        (csr_hit),
    .rdata_o      (csr_rdata),
    .irq_enable_o (irq_enable_o),
    .epc_o        (epc_o)
  );

  // counters see the same bus
  perf_counters u_perf (
    .clk         (clk),
    .rst_n       (rst_n),
    .acc_valid_i (acc_valid),
    .acc_addr_i  (acc_addr),
    .acc_op_i    (acc_op),
    .acc_wdata_i (acc_wdata),
    .events_i    (events_i),
    .hit_o       (perf_hit),
    .rdata_o     (perf_rdata)
  );

endmodule

`default_nettype wire

// File: verilog/perf_counters.sv
// performance event enable, mode register and saturating event counters
`timescale 1ns/1ns
`default_nettype none

module perf_counters import csr_pkg::*, perf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // access bus
  input  logic       acc_valid_i,
  input  csr_addr_t  acc_addr_i,
  input  csr_op_t    acc_op_i,
  input  csr_data_t  acc_wdata_i,

  // raw events, cycle bit unused
  input  event_vec_t events_i,

  output logic       hit_o,
  output csr_data_t  rdata_o
);

  event_vec_t pcer_q;
  pcmr_t      pcmr_q;
  event_vec_t inc_q;
  perf_cnt_t  cnt_q [N_EVENTS];
  perf_cnt_t  cnt_d [N_EVENTS];

  event_vec_t ev_in;
  event_vec_t inc;
  csr_addr_t  cnt_off;
  logic       sel_pcer;
  logic       sel_pcmr;
  logic       sel_all;
  logic       sel_cnt;
  logic       wr_en;
  csr_data_t  new_val;

  //////////////////////////////////////////////////////////////////////
  // event qualify
  //////////////////////////////////////////////////////////////////////

  // cycle event made here
  always_comb
  begin
    ev_in           = events_i;
    ev_in[EV_CYCLE] = 1'b1;
  end

  // enabled per event and globally
  assign inc = ev_in & pcer_q & {N_EVENTS{pcmr_q[PCMR_EN_BIT]}};

  //////////////////////////////////////////////////////////////////////
  // decode and read
  //////////////////////////////////////////////////////////////////////

  assign cnt_off  = acc_addr_i - CSR_PCCR_BASE;
  assign sel_pcer = acc_valid_i && (acc_addr_i == CSR_PCER);
  assign sel_pcmr = acc_valid_i && (acc_addr_i == CSR_PCMR);
  assign sel_all  = acc_valid_i && (acc_addr_i == CSR_PCCR_ALL);
  assign sel_cnt  = acc_valid_i && (acc_addr_i >= CSR_PCCR_BASE)
                    && (cnt_off < csr_addr_t'(N_EVENTS));

  assign hit_o = sel_pcer | sel_pcmr | sel_all | sel_cnt;

  // all-counters address reads zero
  always_comb
  begin
    rdata_o = '0;
    if (sel_pcer)
      rdata_o[N_EVENTS-1:0] = pcer_q;
    if (sel_pcmr)
      rdata_o[1:0] = pcmr_q;
    for (int i = 0; i < N_EVENTS; i++)
    begin
      if (sel_cnt && (int'(cnt_off) == i))
        rdata_o = cnt_q[i];
    end
  end

  assign wr_en   = acc_valid_i && (acc_op_i != CSR_OP_NONE);
  // for pcer and pcmr, single counters get their own below
  assign new_val = csr_apply_op(acc_op_i, rdata_o, acc_wdata_i);

  //////////////////////////////////////////////////////////////////////
  // counter next state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < N_EVENTS; i++)
    begin
      cnt_d[i] = cnt_q[i];
      // holds at all ones when saturating
      if (inc_q[i] && (!pcmr_q[PCMR_SAT_BIT] || (cnt_q[i] != '1)))
        cnt_d[i] = cnt_q[i] + 1'b1;
      // bus access replaces the increment
      if (wr_en && (sel_all || (sel_cnt && (int'(cnt_off) == i))))
        cnt_d[i] = csr_apply_op(acc_op_i, cnt_q[i], acc_wdata_i);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pcer_q <= '0;
      pcmr_q <= PCMR_RESET;
      inc_q  <= '0;
      for (int i = 0; i < N_EVENTS; i++)
        cnt_q[i] <= '0;
    end
    else
    begin
      if (wr_en && sel_pcer)
        pcer_q <= new_val[N_EVENTS-1:0];
      if (wr_en && sel_pcmr)
        pcmr_q <= new_val[1:0];
      // one cycle between event and count
      inc_q <= inc;
      for (int i = 0; i < N_EVENTS; i++)
        cnt_q[i] <= cnt_d[i];
    end
  end

endmodule

`default_nettype wire

// File: verilog/perf_pkg.sv
// performance event indices, counter types and mode register layout
`default_nettype none

package perf_pkg;

  // one counter per event
  localparam int N_EVENTS = 6;

  typedef logic [N_EVENTS-1:0] event_vec_t;
  typedef logic [31:0]         perf_cnt_t;
  typedef logic [1:0]          pcmr_t;

  //////////////////////////////////////////////////////////////////////
  // event indices
  //////////////////////////////////////////////////////////////////////

  // cycle is generated inside the counter block
  localparam int EV_CYCLE  = 0;
  localparam int EV_INSTR  = 1;
  localparam int EV_LOAD   = 2;
  localparam int EV_STORE  = 3;
  localparam int EV_BRANCH = 4;
  localparam int EV_STALL  = 5;

  // mode register bits
  localparam int    PCMR_EN_BIT  = 0;
  localparam int    PCMR_SAT_BIT = 1;
  // counting and saturation on out of reset
  localparam pcmr_t PCMR_RESET   = 2'b11;

endpackage

`default_nettype wire
